// File: design/crc32d8.sv
//======================================================================
// crc-32, one byte per enabled cycle
// reflected ieee 802.3 polynomial, lsb of each byte first,
// all-ones preload on reset and on a synchronous clear
//======================================================================

`timescale 1ns/1ps

module crc32d8
	import eth_mac_rx_pkg::*;
(
	input  logic     pe_rx_clk,
	input  logic     pe_rx_rstn,
	input  logic     clr,
	input  rx_byte_t data,
	input  logic     en,
	output rx_word_t crc
);

// 04c11db7 bit-reversed, the register shifts towards bit 0
localparam rx_word_t CRC_POLY_REFL = 32'hedb88320;

// running remainder, reflected order
rx_word_t crc_q;
rx_word_t crc_next;

//======================================================================
// byte update
//======================================================================

// eight serial steps unrolled into one cycle
// each step folds one data bit, bit 0 first as on the wire
always_comb
begin
	crc_next = crc_q;
	for (int i = 0; i < 8; i++)
	begin
		if (crc_next[0] ^ data[i])
			crc_next = (crc_next >> 1) ^ CRC_POLY_REFL;
		else
			crc_next = crc_next >> 1;
	end
end

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		crc_q <= '1;
	else if (clr)
		// new frame or logic clear
		crc_q <= '1;
	else if (en)
		crc_q <= crc_next;
end

// present the remainder in normal bit order
// no final inversion, the caller compares against the residue
assign crc = {<<{crc_q}};

endmodule

// File: design/eth_mac_pe_rx.sv
//======================================================================
// ethernet mac receive protocol engine
// assembles bytes from line nibbles, hunts preamble and start
// delimiter, feeds frame bytes to the crc and the protocol handler,
// enforces the length limit and reports frame errors
//======================================================================

`timescale 1ns/1ps

module eth_mac_pe_rx
	import eth_mac_rx_pkg::*;
#(
	parameter int MAX_FRAME_BYTES = 1518
)
(
	input  logic       pe_rx_clk,
	input  logic       pe_rx_rstn,

	// line side
	input  logic [3:0] eth_rx,
	input  logic       eth_rx_ctrl,
	input  logic       eth_rx_er,

	// control
	input  logic       pe_rx_clk_enable,
	input  logic       pe_rx_logic_clr,
	output logic       pe_rx_data_start,
	output logic       pe_rx_data_end,

	// configuration
	input  mac_addr_t  r_sa_macaddr,
	input  logic [3:0] r_pre_byte,
	input  logic       r_cs_rm,

	// receive buffer
	input  logic       rxdb_fifo_ready,
	output logic       rxdb_pe2fifo_we,
	output rx_word_t   rxdb_pe2fifo_wdata,
	output logic       rxdb_pe2fifo_we_done,

	// frame status
	output rx_len_t    r_rx_payload_byte_length,
	output logic       rx_crc_err,
	output logic       rx_len_err,
	output logic       rx_line_err,
	output logic       rx_addr_match
);

localparam rx_len_t MAX_LEN = rx_len_t'(MAX_FRAME_BYTES);

//======================================================================
// line input register and nibble assembly
//======================================================================

logic [3:0] eth_rx_q;
logic       ctrl_q;
logic       ctrl_d;
logic       er_q;

// toggles while ctrl is up and is high on the second nibble
logic       nib_sel;
logic [3:0] nib_lo;
rx_byte_t   rx_byte;
logic       byte_vld;

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
	begin
		ctrl_q <= 1'b0;
		ctrl_d <= 1'b0;
		er_q   <= 1'b0;
	end
	else
	begin
		ctrl_q <= eth_rx_ctrl;
		ctrl_d <= ctrl_q;
		er_q   <= eth_rx_er;
	end
end

// sampled line nibble
always_ff @(posedge pe_rx_clk)
begin
	eth_rx_q <= eth_rx;
end

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
	begin
		nib_sel  <= 1'b0;
		byte_vld <= 1'b0;
	end
	else if (pe_rx_logic_clr || !ctrl_q)
	begin
		// realign on the next ctrl rise
		nib_sel  <= 1'b0;
		byte_vld <= 1'b0;
	end
	else
	begin
		nib_sel  <= ~nib_sel;
		byte_vld <= nib_sel;
	end
end

// low nibble first on the wire
always_ff @(posedge pe_rx_clk)
begin
	if (ctrl_q && !nib_sel)
		nib_lo <= eth_rx_q;
	if (ctrl_q && nib_sel)
		rx_byte <= {eth_rx_q, nib_lo};
end

//======================================================================
// frame state machine
//======================================================================

rx_frame_state_t state;
rx_frame_state_t next_state;

logic       st_detect;
logic       st_payload;
logic       st_handle;
logic       st_end;

logic [3:0] pre_cnt;
logic       sfd_ok;
logic       ctrl_rise;
logic       detect_to_end;
logic       payload_to_handle;
logic       frame_abort;
logic       handle_to_end;
logic       len_over;
logic       rx_handle_done;
rx_len_t    byte_cnt;

assign st_detect  = state == RX_FRAME_DETECT;
assign st_payload = state == RX_FRAME_PAYLOAD;
assign st_handle  = state == RX_FRAME_HANDLE;
assign st_end     = state == RX_FRAME_END;

// only a fresh ctrl rise opens a frame so an aborted frame's tail is ignored
assign ctrl_rise = ctrl_q && !ctrl_d;

// delimiter after enough preamble bytes
assign sfd_ok = st_detect && byte_vld && (rx_byte == SFD_BYTE) && (pre_cnt >= r_pre_byte);

assign detect_to_end = st_detect && !sfd_ok && (!ctrl_q || er_q);

// one more byte than allowed is a length error
assign len_over = byte_vld && (byte_cnt == MAX_LEN);

assign frame_abort = st_payload && (er_q || len_over);

// ctrl gone and the last byte already strobed
assign payload_to_handle = st_payload && !ctrl_q && !byte_vld && !frame_abort;

assign handle_to_end = st_handle && rx_handle_done;

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		state <= RX_FRAME_IDLE;
	else
		state <= next_state;
end

always_comb
begin
	next_state = state;
	if (pe_rx_logic_clr)
		next_state = RX_FRAME_IDLE;
	else
	begin
		case (state)
			RX_FRAME_IDLE:
				if (ctrl_rise && pe_rx_clk_enable)
					next_state = RX_FRAME_DETECT;
			RX_FRAME_DETECT:
				if (sfd_ok)
					next_state = RX_FRAME_PAYLOAD;
				else if (detect_to_end)
					next_state = RX_FRAME_END;
			RX_FRAME_PAYLOAD:
				if (frame_abort)
					next_state = RX_FRAME_END;
				else if (payload_to_handle)
					next_state = RX_FRAME_HANDLE;
			RX_FRAME_HANDLE:
				if (handle_to_end)
					next_state = RX_FRAME_END;
			RX_FRAME_END:
				next_state = RX_FRAME_IDLE;
			default:
				next_state = RX_FRAME_IDLE;
		endcase
	end
end

// saturating count of consecutive preamble bytes
always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		pre_cnt <= '0;
	else if (!st_detect || pe_rx_logic_clr)
		pre_cnt <= '0;
	else if (byte_vld)
	begin
		if (rx_byte != PREAMBLE_BYTE)
			pre_cnt <= '0;
		else if (pre_cnt != 4'hf)
			pre_cnt <= pre_cnt + 4'd1;
	end
end

//======================================================================
// payload bytes, length limit and buffer enable
//======================================================================

logic     byte_we;
logic     byte_done;
logic     write_en_q;
logic     write_en;
logic     frame_open;
rx_word_t crc_val;

// the byte that breaks the limit is not passed on
assign byte_we   = st_payload && byte_vld && !frame_abort;
assign byte_done = payload_to_handle || frame_abort;

// an aborted frame gets no flush and no we_done
assign write_en  = write_en_q && !frame_abort;

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		byte_cnt <= '0;
	else if (!st_payload || pe_rx_logic_clr)
		byte_cnt <= '0;
	else if (byte_we)
		byte_cnt <= byte_cnt + 1'b1;
end

// buffer readiness is taken once at the delimiter
always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		write_en_q <= 1'b0;
	else if (pe_rx_logic_clr || frame_abort || st_end)
		write_en_q <= 1'b0;
	else if (sfd_ok)
		write_en_q <= rxdb_fifo_ready;
end

// frame between start and end pulses
always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		frame_open <= 1'b0;
	else if (pe_rx_logic_clr || st_end)
		frame_open <= 1'b0;
	else if (sfd_ok)
		frame_open <= 1'b1;
end

assign pe_rx_data_start = sfd_ok;
assign pe_rx_data_end   = st_end && frame_open;

//======================================================================
// frame status
//======================================================================

// latched on entry to end and held until the next delimiter
always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
	begin
		rx_crc_err  <= 1'b0;
		rx_len_err  <= 1'b0;
		rx_line_err <= 1'b0;
	end
	else if (pe_rx_logic_clr || sfd_ok)
	begin
		rx_crc_err  <= 1'b0;
		rx_len_err  <= 1'b0;
		rx_line_err <= 1'b0;
	end
	else if (frame_open && (handle_to_end || frame_abort))
	begin
		rx_crc_err  <= crc_val != CRC_RESIDUE;
		rx_len_err  <= frame_abort && len_over;
		rx_line_err <= frame_abort && er_q;
	end
end

//======================================================================
// crc and protocol handler
//======================================================================

// preload at the delimiter
// every passed byte goes in including the fcs
crc32d8 u_crc32d8
(
	.pe_rx_clk  (pe_rx_clk),
	.pe_rx_rstn (pe_rx_rstn),
	.clr        (pe_rx_logic_clr || sfd_ok),
	.data       (rx_byte),
	.en         (byte_we),
	.crc        (crc_val)
);

eth_mac_pe_rx_protocol_handle u_eth_mac_pe_rx_protocol_handle
(
	.pe_rx_clk                (pe_rx_clk),
	.pe_rx_rstn               (pe_rx_rstn),
	.pe_rx_logic_clr          (pe_rx_logic_clr),
	.rx_frame_byte_data       (rx_byte),
	.rx_frame_byte_data_we    (byte_we),
	.rx_frame_byte_data_done  (byte_done),
	.rx_frame_write_en        (write_en),
	.r_sa_macaddr             (r_sa_macaddr),
	.r_cs_rm                  (r_cs_rm),
	.rxdb_pe2fifo_we          (rxdb_pe2fifo_we),
	.rxdb_pe2fifo_wdata       (rxdb_pe2fifo_wdata),
	.rxdb_pe2fifo_we_done     (rxdb_pe2fifo_we_done),
	.rx_handle_done           (rx_handle_done),
	.r_rx_payload_byte_length (r_rx_payload_byte_length),
	.rx_addr_match            (rx_addr_match)
);

endmodule

// File: design/eth_mac_pe_rx_protocol_handle.sv
//======================================================================
// ethernet mac receive protocol handler
// optional fcs strip through a four byte delay line, packing into
// little-endian buffer words, end-of-frame flush, byte count and
// destination address check
//======================================================================

`timescale 1ns/1ps

module eth_mac_pe_rx_protocol_handle
	import eth_mac_rx_pkg::*;
(
	input  logic     pe_rx_clk,
	input  logic     pe_rx_rstn,
	input  logic     pe_rx_logic_clr,

	// from the engine
	input  rx_byte_t rx_frame_byte_data,
	input  logic     rx_frame_byte_data_we,
	input  logic     rx_frame_byte_data_done,
	input  logic     rx_frame_write_en,

	// configuration
	input  mac_addr_t r_sa_macaddr,
	input  logic     r_cs_rm,

	// receive buffer
	output logic     rxdb_pe2fifo_we,
	output rx_word_t rxdb_pe2fifo_wdata,
	output logic     rxdb_pe2fifo_we_done,

	// back to the engine
	output logic     rx_handle_done,
	output rx_len_t  r_rx_payload_byte_length,
	output logic     rx_addr_match
);

//======================================================================
// fcs strip
//======================================================================

// bytes held back, last FCS_BYTES of the frame never leave
rx_byte_t   dly [FCS_BYTES];
logic [2:0] fill;
logic       fwd_we;
rx_byte_t   fwd_byte;

// without strip bytes go straight through
assign fwd_we   = rx_frame_byte_data_we && (!r_cs_rm || fill == 3'(FCS_BYTES));
assign fwd_byte = r_cs_rm ? dly[FCS_BYTES-1] : rx_frame_byte_data;

always_ff @(posedge pe_rx_clk)
begin
	if (rx_frame_byte_data_we)
	begin
		dly[0] <= rx_frame_byte_data;
		for (int i = 1; i < FCS_BYTES; i++)
			dly[i] <= dly[i-1];
	end
end

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		fill <= '0;
	else if (pe_rx_logic_clr || rx_frame_byte_data_done)
		fill <= '0;
	else if (rx_frame_byte_data_we && fill != 3'(FCS_BYTES))
		fill <= fill + 3'd1;
end

//======================================================================
// word packing and buffer writes
//======================================================================

logic [1:0]  idx;
// bytes 0..2 of the word in progress, zero where not yet written
logic [23:0] pack;
// partial word out, we_done next
logic        fin_pend;

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
	begin
		idx                  <= '0;
		pack                 <= '0;
		fin_pend             <= 1'b0;
		rxdb_pe2fifo_we      <= 1'b0;
		rxdb_pe2fifo_we_done <= 1'b0;
		rx_handle_done       <= 1'b0;
	end
	else
	begin
		// strobes default low
		rxdb_pe2fifo_we      <= 1'b0;
		rxdb_pe2fifo_we_done <= 1'b0;
		rx_handle_done       <= 1'b0;
		if (pe_rx_logic_clr)
		begin
			idx      <= '0;
			pack     <= '0;
			fin_pend <= 1'b0;
		end
		else if (rx_frame_byte_data_done)
		begin
			idx  <= '0;
			pack <= '0;
			if (idx != 2'd0)
			begin
				// zero padded last word first
				rxdb_pe2fifo_we <= rx_frame_write_en;
				fin_pend        <= 1'b1;
			end
			else
			begin
				rxdb_pe2fifo_we_done <= rx_frame_write_en;
				rx_handle_done       <= 1'b1;
			end
		end
		else if (fin_pend)
		begin
			fin_pend             <= 1'b0;
			rxdb_pe2fifo_we_done <= rx_frame_write_en;
			rx_handle_done       <= 1'b1;
		end
		else if (fwd_we)
		begin
			if (idx == 2'd3)
			begin
				// fourth byte completes the word
				rxdb_pe2fifo_we <= rx_frame_write_en;
				pack            <= '0;
			end
			else
				pack[{idx, 3'b000} +: 8] <= fwd_byte;
			idx <= idx + 2'd1;
		end
	end
end

// word payload, loaded together with the write strobe
always_ff @(posedge pe_rx_clk)
begin
	if (!rx_frame_byte_data_done && fwd_we && idx == 2'd3)
		rxdb_pe2fifo_wdata <= {fwd_byte, pack};
	else if (rx_frame_byte_data_done && idx != 2'd0)
		rxdb_pe2fifo_wdata <= {8'h00, pack};
end

//======================================================================
// byte count and destination address
//======================================================================

rx_len_t    len_cnt;
logic [2:0] addr_idx;
logic       uni_ok;
logic       bc_ok;
mac_addr_t  mac_shift;

// address byte for the current position, byte 0 from the top
assign mac_shift = r_sa_macaddr >> {3'd5 - addr_idx, 3'b000};

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
	begin
		len_cnt                  <= '0;
		addr_idx                 <= '0;
		uni_ok                   <= 1'b1;
		bc_ok                    <= 1'b1;
		r_rx_payload_byte_length <= '0;
		rx_addr_match            <= 1'b0;
	end
	else if (pe_rx_logic_clr)
	begin
		len_cnt                  <= '0;
		addr_idx                 <= '0;
		uni_ok                   <= 1'b1;
		bc_ok                    <= 1'b1;
		r_rx_payload_byte_length <= '0;
		rx_addr_match            <= 1'b0;
	end
	else if (rx_frame_byte_data_done)
	begin
		// publish and rearm for the next frame
		r_rx_payload_byte_length <= len_cnt;
		rx_addr_match            <= (addr_idx == 3'd6) && (uni_ok || bc_ok);
		len_cnt                  <= '0;
		addr_idx                 <= '0;
		uni_ok                   <= 1'b1;
		bc_ok                    <= 1'b1;
	end
	else
	begin
		// only forwarded bytes count
		if (fwd_we)
			len_cnt <= len_cnt + 1'b1;
		// destination is the first six bytes after the delimiter
		if (rx_frame_byte_data_we && addr_idx != 3'd6)
		begin
			addr_idx <= addr_idx + 3'd1;
			uni_ok   <= uni_ok && (rx_frame_byte_data == mac_shift[7:0]);
			bc_ok    <= bc_ok && (rx_frame_byte_data == 8'hff);
		end
	end
end

endmodule

// File: design/eth_mac_rx_pkg.sv
//======================================================================
// ethernet mac receive path, shared definitions
// frame byte, buffer word, length and address types, the frame
// state encoding and the protocol constants
//======================================================================

package eth_mac_rx_pkg;

	//==================================================================
	// data types
	//==================================================================

	// one frame byte as seen after nibble assembly
	typedef logic [7:0]  rx_byte_t;

	// receive buffer word, byte 0 in bits 7:0
	typedef logic [31:0] rx_word_t;

	// frame byte count
	typedef logic [11:0] rx_len_t;

	// station address, first byte on the wire in bits 47:40
	typedef logic [47:0] mac_addr_t;

	// frame state machine
	typedef enum logic [2:0] {
		RX_FRAME_IDLE,
		RX_FRAME_DETECT,
		RX_FRAME_PAYLOAD,
		RX_FRAME_HANDLE,
		RX_FRAME_END
	} rx_frame_state_t;

	//==================================================================
	// protocol constants
	//==================================================================

	localparam rx_byte_t PREAMBLE_BYTE = 8'h55;
	localparam rx_byte_t SFD_BYTE      = 8'hd5;

	// register value after the fcs has run through, normal bit order
	localparam rx_word_t CRC_RESIDUE   = 32'hc704dd7b;

	// frame check sequence length
	localparam int       FCS_BYTES     = 4;

endpackage

// File: design/eth_mac_rx_top.sv
//======================================================================
// ethernet mac receive path, top level
// nibble line in, 32-bit buffer words and frame status out
//======================================================================

`timescale 1ns/1ps

module eth_mac_rx_top
	import eth_mac_rx_pkg::*;
#(
	// longest accepted frame after the delimiter, fcs included
	parameter int MAX_FRAME_BYTES = 1518
)
(
	input  logic       pe_rx_clk,
	input  logic       pe_rx_rstn,

	// line side
	input  logic [3:0] eth_rx,
	input  logic       eth_rx_ctrl,
	input  logic       eth_rx_er,

	// control
	input  logic       pe_rx_clk_enable,
	input  logic       pe_rx_logic_clr,

	// configuration
	input  mac_addr_t  r_sa_macaddr,
	input  logic [3:0] r_pre_byte,
	input  logic       r_cs_rm,

	// receive buffer
	input  logic       rxdb_fifo_ready,
	output logic       rxdb_pe2fifo_we,
	output rx_word_t   rxdb_pe2fifo_wdata,
	output logic       rxdb_pe2fifo_we_done,

	// frame pulses and status
	output logic       pe_rx_data_start,
	output logic       pe_rx_data_end,
	output rx_len_t    r_rx_payload_byte_length,
	output logic       rx_crc_err,
	output logic       rx_len_err,
	output logic       rx_line_err,
	output logic       rx_addr_match
);

// engine carries the crc and the handler underneath
eth_mac_pe_rx #(
	.MAX_FRAME_BYTES (MAX_FRAME_BYTES)
) u_eth_mac_pe_rx
(
	.pe_rx_clk                (pe_rx_clk),
	.pe_rx_rstn               (pe_rx_rstn),
	.eth_rx                   (eth_rx),
	.eth_rx_ctrl              (eth_rx_ctrl),
	.eth_rx_er                (eth_rx_er),
	.pe_rx_clk_enable         (pe_rx_clk_enable),
	.pe_rx_logic_clr          (pe_rx_logic_clr),
	.pe_rx_data_start         (pe_rx_data_start),
	.pe_rx_data_end           (pe_rx_data_end),
	.r_sa_macaddr             (r_sa_macaddr),
	.r_pre_byte               (r_pre_byte),
	.r_cs_rm                  (r_cs_rm),
	.rxdb_fifo_ready          (rxdb_fifo_ready),
	.rxdb_pe2fifo_we          (rxdb_pe2fifo_we),
	.rxdb_pe2fifo_wdata       (rxdb_pe2fifo_wdata),
	.rxdb_pe2fifo_we_done     (rxdb_pe2fifo_we_done),
	.r_rx_payload_byte_length (r_rx_payload_byte_length),
	.rx_crc_err               (rx_crc_err),
	.rx_len_err               (rx_len_err),
	.rx_line_err              (rx_line_err),
	.rx_addr_match            (rx_addr_match)
);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the receive path simulation with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_eth_mac_rx -o tb_eth_mac_rx_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_eth_mac_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// File: tb.f
design/eth_mac_rx_pkg.sv
design/crc32d8.sv
design/eth_mac_pe_rx_protocol_handle.sv
design/eth_mac_pe_rx.sv
design/eth_mac_rx_top.sv
testbench/tb_eth_mac_rx_assert.sv
testbench/tb_eth_mac_rx.sv

// File: testbench/eth_mac_rx_stim.txt
# line 1: name pre_bytes cs_rm fifo_ready enable macaddr n_bytes n_fill (hex)
# line 2: wire bytes incl preamble, sfd and fcs; line 3: end len crc_err len_err match n_words words
good_fcs_kept 7 0 1 1 313233343536 15 0
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
1 d 0 0 1 4 34333231 38373635 f4392639 000000cb
good_fcs_strip 7 1 1 1 313233343536 15 0
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
1 9 0 0 1 3 34333231 38373635 00000039
bad_fcs_strip 7 1 1 1 313233343536 15 0
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 ca
1 9 1 0 1 3 34333231 38373635 00000039
short_preamble 7 0 1 1 313233343536 11 0
55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
0 0 0 0 0 0
preamble_ok 3 0 1 1 313233343536 11 0
55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
1 d 0 0 1 4 34333231 38373635 f4392639 000000cb
addr_other 7 0 1 1 0a0b0c0d0e0f 15 0
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
1 d 0 0 0 4 34333231 38373635 f4392639 000000cb
addr_broadcast 7 0 1 1 313233343536 14 0
55 55 55 55 55 55 55 d5 ff ff ff ff ff ff 08 00 00 00 00 00
1 c 1 0 1 3 ffffffff 0008ffff 00000000
no_fifo_ready 7 0 0 1 313233343536 15 0
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
1 d 0 0 1 0
len_error 7 0 0 1 313233343536 8 5f0
55 55 55 55 55 55 55 d5
1 5ee 1 1 0 0
clk_disabled 7 0 1 0 313233343536 15 0
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
0 0 0 0 0 0

// File: testbench/tb_eth_mac_rx.sv
//======================================================================
// testbench for the ethernet mac receive path
// replays frames from the stimulus file nibble by nibble, collects
// buffer words and frame status, compares against the expectations
//======================================================================

`timescale 1ns/1ps

module tb_eth_mac_rx
	import eth_mac_rx_pkg::*;
();

localparam int MAX_FRAME_BYTES = 1518;
// ctrl fall to end pulse is a handful of cycles
localparam int END_TIMEOUT     = 60;
// watch window for frames that must stay silent
localparam int QUIET_CYCLES    = 40;

//======================================================================
// dut signals
//======================================================================

logic       pe_rx_clk;
logic       pe_rx_rstn;
logic [3:0] eth_rx;
logic       eth_rx_ctrl;
logic       eth_rx_er;
logic       pe_rx_clk_enable;
logic       pe_rx_logic_clr;
mac_addr_t  r_sa_macaddr;
logic [3:0] r_pre_byte;
logic       r_cs_rm;
logic       rxdb_fifo_ready;
logic       rxdb_pe2fifo_we;
rx_word_t   rxdb_pe2fifo_wdata;
logic       rxdb_pe2fifo_we_done;
logic       pe_rx_data_start;
logic       pe_rx_data_end;
rx_len_t    r_rx_payload_byte_length;
logic       rx_crc_err;
logic       rx_len_err;
logic       rx_line_err;
logic       rx_addr_match;

eth_mac_rx_top #(
	.MAX_FRAME_BYTES (MAX_FRAME_BYTES)
) i_dut
(
	.pe_rx_clk                (pe_rx_clk),
	.pe_rx_rstn               (pe_rx_rstn),
	.eth_rx                   (eth_rx),
	.eth_rx_ctrl              (eth_rx_ctrl),
	.eth_rx_er                (eth_rx_er),
	.pe_rx_clk_enable         (pe_rx_clk_enable),
	.pe_rx_logic_clr          (pe_rx_logic_clr),
	.r_sa_macaddr             (r_sa_macaddr),
	.r_pre_byte               (r_pre_byte),
	.r_cs_rm                  (r_cs_rm),
	.rxdb_fifo_ready          (rxdb_fifo_ready),
	.rxdb_pe2fifo_we          (rxdb_pe2fifo_we),
	.rxdb_pe2fifo_wdata       (rxdb_pe2fifo_wdata),
	.rxdb_pe2fifo_we_done     (rxdb_pe2fifo_we_done),
	.pe_rx_data_start         (pe_rx_data_start),
	.pe_rx_data_end           (pe_rx_data_end),
	.r_rx_payload_byte_length (r_rx_payload_byte_length),
	.rx_crc_err               (rx_crc_err),
	.rx_len_err               (rx_len_err),
	.rx_line_err              (rx_line_err),
	.rx_addr_match            (rx_addr_match)
);

// 40 ns period
always #20 pe_rx_clk = ~pe_rx_clk;

//======================================================================
// current record and observed results
//======================================================================

int         fd;
string      tname;
logic [3:0] cfg_pre;
logic       cfg_cs;
logic       cfg_rdy;
logic       cfg_en;
mac_addr_t  cfg_mac;
rx_byte_t   frame_bytes[$];
rx_word_t   exp_words[$];
rx_word_t   got_words[$];
logic       exp_end;
rx_len_t    exp_len;
logic       exp_crc;
logic       exp_lenerr;
logic       exp_match;

int         start_cnt;
int         end_cnt;
int         done_cnt;
rx_len_t    snap_len;
logic       snap_crc;
logic       snap_lenerr;
logic       snap_lineerr;
logic       snap_match;

int         test_err;
int         err_total;
int         tests_run;
int         tests_failed;
logic [31:0] lfsr_state;

// outputs are registered on the rising edge, sample them on the falling one
always @(negedge pe_rx_clk)
begin
	if (rxdb_pe2fifo_we)
		got_words.push_back(rxdb_pe2fifo_wdata);
	if (rxdb_pe2fifo_we_done)
		done_cnt++;
	if (pe_rx_data_start)
		start_cnt++;
	if (pe_rx_data_end)
	begin
		end_cnt++;
		snap_len     = r_rx_payload_byte_length;
		snap_crc     = rx_crc_err;
		snap_lenerr  = rx_len_err;
		snap_lineerr = rx_line_err;
		snap_match   = rx_addr_match;
	end
end

//======================================================================
// helpers
//======================================================================

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// filler byte depends on the whole byte index
function automatic rx_byte_t fill_byte(input int idx);
	fill_byte = rx_byte_t'((idx ^ (idx >> 8)) & 8'hff);
endfunction

task automatic check_value(input string what, input logic [31:0] expv,
	input logic [31:0] actv);
	assert (expv === actv)
	else
	begin
		$display("ERR %s %s expected %h actual %h", tname, what, expv, actv);
		test_err++;
	end
endtask

// one record: config line, wire bytes line, expectation line
task automatic read_record(output bit ok);
	int          code;
	int          nbytes;
	int          nfill;
	int          nwords;
	int          i;
	logic [31:0] v;
	string       line;
	bit          got_name;
	ok       = 0;
	got_name = 0;
	while (!got_name)
	begin
		code = $fscanf(fd, "%s", tname);
		if (code != 1)
			return;
		// comment lines are skipped whole
		if (tname[0] == "#")
			code = $fgets(line, fd);
		else
			got_name = 1;
	end
	code = $fscanf(fd, "%h %h %h %h %h %h %h", cfg_pre, cfg_cs, cfg_rdy, cfg_en,
		cfg_mac, nbytes, nfill);
	if (code != 7)
	begin
		$display("stimulus record %s has a broken config line", tname);
		err_total++;
		return;
	end
	frame_bytes.delete();
	for (i = 0; i < nbytes; i++)
	begin
		code = $fscanf(fd, "%h", v);
		frame_bytes.push_back(v[7:0]);
	end
	for (i = 0; i < nfill; i++)
		frame_bytes.push_back(fill_byte(i));
	code = $fscanf(fd, "%h %h %h %h %h %h", exp_end, exp_len, exp_crc, exp_lenerr,
		exp_match, nwords);
	if (code != 6)
	begin
		$display("stimulus record %s has a broken expectation line", tname);
		err_total++;
		return;
	end
	exp_words.delete();
	for (i = 0; i < nwords; i++)
	begin
		code = $fscanf(fd, "%h", v);
		exp_words.push_back(v);
	end
	ok = 1;
endtask

task automatic drive_nibble(input logic [3:0] n);
	@(posedge pe_rx_clk);
	#2;
	eth_rx      = n;
	eth_rx_ctrl = 1'b1;
endtask

// low nibble first, ctrl dropped after the last one
task automatic drive_frame();
	int i;
	for (i = 0; i < frame_bytes.size(); i++)
	begin
		drive_nibble(frame_bytes[i][3:0]);
		drive_nibble(frame_bytes[i][7:4]);
	end
	@(posedge pe_rx_clk);
	#2;
	eth_rx_ctrl = 1'b0;
	eth_rx      = 4'h0;
endtask

//======================================================================
// one test per record
//======================================================================

task automatic run_test();
	int wait_cnt;
	int k;
	int gap;
	bit exp_done;
	test_err = 0;
	got_words.delete();
	start_cnt = 0;
	end_cnt   = 0;
	done_cnt  = 0;

	@(posedge pe_rx_clk);
	#2;
	r_pre_byte       = cfg_pre;
	r_cs_rm          = cfg_cs;
	rxdb_fifo_ready  = cfg_rdy;
	pe_rx_clk_enable = cfg_en;
	r_sa_macaddr     = cfg_mac;
	drive_frame();

	if (exp_end)
	begin
		wait_cnt = 0;
		while (end_cnt == 0 && wait_cnt < END_TIMEOUT)
		begin
			@(posedge pe_rx_clk);
			wait_cnt++;
		end
		if (end_cnt == 0)
		begin
			$display("test %s: frame end pulse never came", tname);
			test_err++;
		end
	end
	else
	begin
		// nothing may happen, just watch
		for (wait_cnt = 0; wait_cnt < QUIET_CYCLES; wait_cnt++)
			@(posedge pe_rx_clk);
	end

	// only a completed frame with a ready buffer finishes with we_done
	exp_done = exp_end && cfg_rdy && !exp_lenerr;

	check_value("start pulses", exp_end, start_cnt);
	check_value("end pulses", exp_end, end_cnt);
	check_value("we_done pulses", exp_done, done_cnt);
	check_value("word count", exp_words.size(), got_words.size());
	for (k = 0; k < exp_words.size() && k < got_words.size(); k++)
		check_value($sformatf("word %0d", k), exp_words[k], got_words[k]);
	if (exp_end && end_cnt != 0)
	begin
		check_value("length", exp_len, snap_len);
		check_value("crc error", exp_crc, snap_crc);
		check_value("length error", exp_lenerr, snap_lenerr);
		check_value("line error", 1'b0, snap_lineerr);
		check_value("address match", exp_match, snap_match);
	end

	tests_run++;
	err_total += test_err;
	if (test_err == 0)
		$display("test %s: ok", tname);
	else
	begin
		$display("test %s: %0d mismatches", tname, test_err);
		tests_failed++;
	end

	// idle gap of 2 to 9 cycles
	gap = 0;
	for (k = 0; k < 3; k++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		gap = (gap << 1) | lfsr_state[0];
	end
	repeat (gap + 2) @(posedge pe_rx_clk);
endtask

//======================================================================
// main sequence
//======================================================================

initial
begin
	bit ok;
	pe_rx_clk        = 1'b0;
	pe_rx_rstn       = 1'b0;
	eth_rx           = 4'h0;
	eth_rx_ctrl      = 1'b0;
	eth_rx_er        = 1'b0;
	pe_rx_clk_enable = 1'b1;
	pe_rx_logic_clr  = 1'b0;
	r_sa_macaddr     = '0;
	r_pre_byte       = 4'd7;
	r_cs_rm          = 1'b0;
	rxdb_fifo_ready  = 1'b1;
	lfsr_state       = 32'hc49dbc06;
	err_total        = 0;
	tests_run        = 0;
	tests_failed     = 0;

	repeat (8) @(posedge pe_rx_clk);
	#2;
	pe_rx_rstn = 1'b1;
	repeat (2) @(posedge pe_rx_clk);

	fd = $fopen("testbench/eth_mac_rx_stim.txt", "r");
	if (fd == 0)
	begin
		$display("stimulus file could not be opened");
		err_total++;
	end
	else
	begin
		read_record(ok);
		while (ok)
		begin
			run_test();
			read_record(ok);
		end
		$fclose(fd);
	end

	$display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
		tests_run - tests_failed, tests_failed, err_total);
	if (err_total == 0 && tests_failed == 0 && tests_run > 0)
		$display("Test completed successfully");
	else
		$display("Test failed");
	$finish;
end

endmodule

// File: testbench/tb_eth_mac_rx_assert.sv
//======================================================================
// protocol assertions on the receive path top level
//======================================================================

`timescale 1ns/1ps

module tb_eth_mac_rx_assert
(
	input logic pe_rx_clk,
	input logic pe_rx_rstn,
	input logic rxdb_pe2fifo_we,
	input logic rxdb_pe2fifo_we_done,
	input logic pe_rx_data_start,
	input logic pe_rx_data_end
);

// between a start pulse and its end pulse
logic in_frame;

always_ff @(posedge pe_rx_clk or negedge pe_rx_rstn)
begin
	if (!pe_rx_rstn)
		in_frame <= 1'b0;
	else if (pe_rx_data_start)
		in_frame <= 1'b1;
	else if (pe_rx_data_end)
		in_frame <= 1'b0;
end

a_we_in_frame: assert property (@(posedge pe_rx_clk) disable iff (!pe_rx_rstn)
	rxdb_pe2fifo_we |-> in_frame)
	else $error("buffer write outside a frame");

a_done_pulse: assert property (@(posedge pe_rx_clk) disable iff (!pe_rx_rstn)
	rxdb_pe2fifo_we_done |=> !rxdb_pe2fifo_we_done)
	else $error("we_done longer than one cycle");

// start and end alternate
a_start_alt: assert property (@(posedge pe_rx_clk) disable iff (!pe_rx_rstn)
	pe_rx_data_start |-> !in_frame)
	else $error("second start pulse without an end");

a_end_alt: assert property (@(posedge pe_rx_clk) disable iff (!pe_rx_rstn)
	pe_rx_data_end |-> in_frame)
	else $error("end pulse without a start");

endmodule

bind eth_mac_rx_top tb_eth_mac_rx_assert u_rx_assert
(
	.pe_rx_clk            (pe_rx_clk),
	.pe_rx_rstn           (pe_rx_rstn),
	.rxdb_pe2fifo_we      (rxdb_pe2fifo_we),
	.rxdb_pe2fifo_we_done (rxdb_pe2fifo_we_done),
	.pe_rx_data_start     (pe_rx_data_start),
	.pe_rx_data_end       (pe_rx_data_end)
);
